/* src/mrd_pkg.sv */
//--------------------------------------------------------------------
// mixed radix DFT control package
// width types, sequencer states, table limits and the factor divider
// shared by planner, counter and address generator
//--------------------------------------------------------------------

package mrd_pkg;

	//------------------------------------------------------------------
	// widths
	//------------------------------------------------------------------

	// frame length, sample index or RAM address
	typedef logic [11:0] pts_t;

	// radix factor, one of 1 2 3 4 5
	typedef logic [2:0] fac_t;

	// number of factors found for a frame
	typedef logic [2:0] nfac_t;

	// stage number inside the compute phase
	typedef logic [2:0] stage_t;

	//------------------------------------------------------------------
	// sequencer
	//------------------------------------------------------------------

	// wait for sop, sink frame, run stages, source frame
	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SINK,
		ST_CALC,
		ST_SOURCE
	} ctrl_state_t;

	//------------------------------------------------------------------
	// limits
	//------------------------------------------------------------------

	// entries per stage table
	localparam int MAX_STAGES = 6;

	// sop to plan_done, one load cycle plus one per table entry
	localparam int PLAN_CYCLES = 7;

	// divide by one radix factor
	// powers of two by shift, 3 and 5 by constant divide
	function automatic pts_t div_by_fac(input pts_t num, input fac_t fac);
		pts_t quo;
		case (fac)
			3'd2: quo = num >> 1;
			3'd3: quo = num / 12'd3;
			3'd4: quo = num >> 2;
			3'd5: quo = num / 12'd5;
			default: quo = num;
		endcase
		return quo;
	endfunction

endpackage

/* src/mrd_factor_plan.sv */
//--------------------------------------------------------------------
// factor planner
// splits the frame length into up to six radix factors (4, 2, 5, 3)
// and builds the per-stage factor, quotient and twiddle tables
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_factor_plan (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic                                     sink_sop,
	input  mrd_pkg::pts_t                            dftpts,
	output mrd_pkg::fac_t [0:mrd_pkg::MAX_STAGES-1]  nf,
	output mrd_pkg::pts_t [0:mrd_pkg::MAX_STAGES-1]  twdl_demontr,
	output mrd_pkg::pts_t [0:mrd_pkg::MAX_STAGES-1]  dftpts_div_nf,
	output mrd_pkg::nfac_t                           num_factors,
	output logic                                     plan_done,
	output logic                                     plan_err
);

	// step 0 is idle, steps 1..6 fill one table entry each
	mrd_pkg::stage_t step;
	mrd_pkg::pts_t   remain;
	mrd_pkg::pts_t   quo;
	mrd_pkg::fac_t   next_factor;
	logic            last_step;

	assign last_step = (step == mrd_pkg::stage_t'(mrd_pkg::PLAN_CYCLES - 1));

	//------------------------------------------------------------------
	// factor pick
	//------------------------------------------------------------------

	// first of 4, 2, 5, 3 that divides the remainder
	always_comb begin
		if (remain[1:0] == 2'b00)
			next_factor = 3'd4;
		else if (!remain[0])
			next_factor = 3'd2;
		else if (remain % 12'd5 == 12'd0)
			next_factor = 3'd5;
		else if (remain % 12'd3 == 12'd0)
			next_factor = 3'd3;
		else
			next_factor = 3'd1;
	end

	// remainder left after this step
	assign quo = mrd_pkg::div_by_fac(remain, next_factor);

	//------------------------------------------------------------------
	// step counter and status
	//------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step        <= '0;
			num_factors <= '0;
			plan_done   <= 1'b0;
			plan_err    <= 1'b0;
		end else begin
			plan_done <= (step != '0) && last_step;
			if (sink_sop) begin
				step        <= 3'd1;
				num_factors <= '0;
				plan_err    <= 1'b0;
			end else if (step != '0) begin
				step <= last_step ? '0 : step + 3'd1;
				// factor 1 means nothing left to split
				if (next_factor != 3'd1)
					num_factors <= num_factors + 3'd1;
				// a clean plan ends with remainder 1
				if (last_step)
					plan_err <= (quo != 12'd1);
			end
		end
	end

	//------------------------------------------------------------------
	// tables
	//------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (sink_sop) begin
			remain          <= dftpts;
			twdl_demontr[0] <= dftpts;
		end else if (step != '0) begin
			remain <= quo;
		end
		for (int i = 0; i < mrd_pkg::MAX_STAGES; i++) begin
			// entry i filled on step i+1
			if (step == mrd_pkg::stage_t'(i + 1)) begin
				nf[i]            <= next_factor;
				dftpts_div_nf[i] <= mrd_pkg::div_by_fac(twdl_demontr[0], next_factor);
			end
			// span of stage i is the remainder before step i+1
			if (i > 0 && step == mrd_pkg::stage_t'(i))
				twdl_demontr[i] <= quo;
		end
	end

endmodule

/* src/mrd_ctrl_fsm.sv */
//--------------------------------------------------------------------
// stage sequencer
// wait, sink, compute and source phases over the single sample RAM,
// with a start pulse on the first cycle of each phase
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_ctrl_fsm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 sink_sop,
	input  logic                 plan_done,
	input  logic                 plan_err,
	input  logic                 sink_last,
	input  logic                 calc_last,
	input  logic                 src_last,
	output mrd_pkg::ctrl_state_t state,
	output logic                 sink_start,
	output logic                 calc_start,
	output logic                 src_start,
	output logic                 frame_done
);

	// events seen earlier in the sink phase
	logic sink_seen;
	logic plan_seen;
	logic sink_done;
	logic plan_ready;

	// sop only counts while idle
	assign sink_start = sink_sop && (state == mrd_pkg::ST_WAIT);

	assign sink_done  = sink_seen | sink_last;
	assign plan_ready = plan_seen | plan_done;

	//------------------------------------------------------------------
	// state register
	//------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= mrd_pkg::ST_WAIT;
			sink_seen  <= 1'b0;
			plan_seen  <= 1'b0;
			calc_start <= 1'b0;
			src_start  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// pulses by default
			calc_start <= 1'b0;
			src_start  <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				mrd_pkg::ST_WAIT: begin
					if (sink_start) begin
						state     <= mrd_pkg::ST_SINK;
						// one sample frame ends in the sop cycle
						sink_seen <= sink_last;
						plan_seen <= 1'b0;
					end
				end
				mrd_pkg::ST_SINK: begin
					// leave once samples and plan are both in
					if (sink_done && plan_ready) begin
						sink_seen <= 1'b0;
						plan_seen <= 1'b0;
						if (plan_err) begin
							// bad size skips the stages
							state     <= mrd_pkg::ST_SOURCE;
							src_start <= 1'b1;
						end else begin
							state      <= mrd_pkg::ST_CALC;
							calc_start <= 1'b1;
						end
					end else begin
						sink_seen <= sink_done;
						plan_seen <= plan_ready;
					end
				end
				mrd_pkg::ST_CALC: begin
					if (calc_last) begin
						state     <= mrd_pkg::ST_SOURCE;
						src_start <= 1'b1;
					end
				end
				mrd_pkg::ST_SOURCE: begin
					// lines up with the last registered src_valid
					if (src_last) begin
						state      <= mrd_pkg::ST_WAIT;
						frame_done <= 1'b1;
					end
				end
				default: state <= mrd_pkg::ST_WAIT;
			endcase
		end
	end

endmodule

/* src/mrd_stage_counter.sv */
//--------------------------------------------------------------------
// phase counters
// linear sample count for sink and source, nested element, offset,
// block and stage counts for the compute phase
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_stage_counter (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  mrd_pkg::pts_t                           dftpts,
	input  logic                                    sink_sop,
	input  logic                                    sink_start,
	input  logic                                    calc_start,
	input  logic                                    src_start,
	input  mrd_pkg::fac_t [0:mrd_pkg::MAX_STAGES-1] nf,
	input  mrd_pkg::pts_t [0:mrd_pkg::MAX_STAGES-1] twdl_demontr,
	input  mrd_pkg::nfac_t                          num_factors,
	output mrd_pkg::pts_t                           sample_idx,
	output mrd_pkg::fac_t                           elem,
	output mrd_pkg::pts_t                           offset,
	output mrd_pkg::pts_t                           block_base,
	output mrd_pkg::stage_t                         stage,
	output logic                                    count_valid,
	output logic                                    sink_last,
	output logic                                    calc_last,
	output logic                                    src_last
);

	mrd_pkg::pts_t   n_lat, n_cur, samp_cnt;
	mrd_pkg::pts_t   offset_q, base_q, span, sub_span;
	mrd_pkg::fac_t   elem_q, factor;
	mrd_pkg::stage_t stage_q;
	logic            sink_go, samp_go, samp_run, samp_src, samp_valid, samp_last, is_src;
	logic            calc_run, calc_valid, elem_wrap, off_wrap, blk_wrap, stage_wrap;

	//------------------------------------------------------------------
	// sample counter
	//------------------------------------------------------------------

	// sop accepted by the sequencer, count 0 shows in this cycle
	assign sink_go    = sink_sop & sink_start;
	assign n_cur      = sink_go ? dftpts : n_lat;
	assign samp_go    = sink_go | src_start;
	assign samp_valid = samp_go | samp_run;
	assign sample_idx = samp_go ? '0 : samp_cnt;
	assign samp_last  = samp_valid && (sample_idx == n_cur - 12'd1);
	assign is_src     = src_start | (samp_src & ~sink_go);
	assign sink_last  = samp_last & ~is_src;
	assign src_last   = samp_last & is_src;

	//------------------------------------------------------------------
	// butterfly counters
	//------------------------------------------------------------------

	// m fastest, then j, then block base, then stage
	assign elem       = calc_start ? '0 : elem_q;
	assign offset     = calc_start ? '0 : offset_q;
	assign block_base = calc_start ? '0 : base_q;
	assign stage      = calc_start ? '0 : stage_q;
	assign calc_valid = calc_start | calc_run;

	assign factor   = nf[stage];
	assign span     = twdl_demontr[stage];
	assign sub_span = mrd_pkg::div_by_fac(span, factor);

	assign elem_wrap  = (elem == factor - 3'd1);
	assign off_wrap   = (offset == sub_span - 12'd1);
	assign blk_wrap   = (block_base + span >= n_lat);
	assign stage_wrap = ({1'b0, stage} + 4'd1 >= {1'b0, num_factors});
	assign calc_last  = calc_valid & elem_wrap & off_wrap & blk_wrap & stage_wrap;

	assign count_valid = samp_valid | calc_valid;

	// count values, load from the presented value every active cycle
	always_ff @(posedge clk) begin
		if (sink_go)
			n_lat <= dftpts;
		if (samp_valid)
			samp_cnt <= sample_idx + 12'd1;
		if (calc_valid) begin
			elem_q   <= elem_wrap ? '0 : elem + 3'd1;
			offset_q <= !elem_wrap ? offset : (off_wrap ? '0 : offset + 12'd1);
			base_q   <= !(elem_wrap && off_wrap) ? block_base :
			            (blk_wrap ? '0 : block_base + span);
			stage_q  <= (elem_wrap && off_wrap && blk_wrap) ? stage + 3'd1 : stage;
		end
	end

	// run flags drop after the last count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			samp_run <= 1'b0;
			samp_src <= 1'b0;
			calc_run <= 1'b0;
		end else begin
			if (samp_valid)
				samp_run <= ~samp_last;
			if (samp_go)
				samp_src <= src_start;
			if (calc_valid)
				calc_run <= ~calc_last;
		end
	end

endmodule

/* src/mrd_addr_gen.sv */
//--------------------------------------------------------------------
// RAM address generator
// turns phase counts into registered strobes, address, stage, element
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_addr_gen (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  mrd_pkg::ctrl_state_t                    state,
	input  logic                                    count_valid,
	input  mrd_pkg::pts_t                           sample_idx,
	input  mrd_pkg::fac_t                           elem,
	input  mrd_pkg::pts_t                           offset,
	input  mrd_pkg::pts_t                           block_base,
	input  mrd_pkg::stage_t                         stage,
	input  mrd_pkg::pts_t [0:mrd_pkg::MAX_STAGES-1] twdl_demontr,
	input  mrd_pkg::fac_t [0:mrd_pkg::MAX_STAGES-1] nf,
	output logic                                    mem_wr,
	output logic                                    mem_rd,
	output logic                                    src_valid,
	output mrd_pkg::pts_t                           mem_addr,
	output mrd_pkg::stage_t                         stage_idx,
	output mrd_pkg::fac_t                           elem_idx
);

	mrd_pkg::pts_t sub_span;
	mrd_pkg::pts_t calc_addr;
	mrd_pkg::pts_t next_addr;
	logic          in_calc;

	// L' = L / factor of this stage
	assign sub_span = mrd_pkg::div_by_fac(twdl_demontr[stage], nf[stage]);

	// base + j + m*L'
	assign calc_addr = block_base + offset + mrd_pkg::pts_t'(elem) * sub_span;

	assign in_calc   = (state == mrd_pkg::ST_CALC);
	assign next_addr = in_calc ? calc_addr : sample_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wr    <= 1'b0;
			mem_rd    <= 1'b0;
			src_valid <= 1'b0;
			mem_addr  <= '0;
			stage_idx <= '0;
			elem_idx  <= '0;
		end else begin
			// sop cycle is still ST_WAIT, so it writes too
			mem_wr    <= count_valid && (state == mrd_pkg::ST_WAIT ||
			                             state == mrd_pkg::ST_SINK);
			mem_rd    <= count_valid && in_calc;
			src_valid <= count_valid && (state == mrd_pkg::ST_SOURCE);
			if (count_valid)
				mem_addr <= next_addr;
			// stage and element only mean something in compute
			if (count_valid && in_calc) begin
				stage_idx <= stage;
				elem_idx  <= elem;
			end
		end
	end

endmodule

/* src/mrd_ctrl_top.sv */
//--------------------------------------------------------------------
// mixed radix DFT control top
// planner, sequencer, phase counters and RAM address generator
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_ctrl_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            sink_sop,
	input  mrd_pkg::pts_t   dftpts,
	output logic            mem_wr,
	output logic            mem_rd,
	output logic            src_valid,
	output mrd_pkg::pts_t   mem_addr,
	output mrd_pkg::stage_t stage_idx,
	output mrd_pkg::fac_t   elem_idx,
	output mrd_pkg::nfac_t  num_factors,
	output logic            plan_err,
	output logic            frame_done
);

	mrd_pkg::fac_t [0:mrd_pkg::MAX_STAGES-1] nf;
	mrd_pkg::pts_t [0:mrd_pkg::MAX_STAGES-1] twdl_demontr;
	mrd_pkg::ctrl_state_t state;
	mrd_pkg::pts_t   sample_idx, offset, block_base;
	mrd_pkg::fac_t   elem;
	mrd_pkg::stage_t stage;
	logic            plan_done, sink_start, calc_start, src_start;
	logic            sink_last, calc_last, src_last, count_valid;

	// planner restarts only on a sop the sequencer accepts
	// N/factor table is for the butterfly datapath, not used here
	mrd_factor_plan u_plan (
		.clk(clk), .rst_n(rst_n), .sink_sop(sink_start), .dftpts(dftpts),
		.nf(nf), .twdl_demontr(twdl_demontr), .dftpts_div_nf(),
		.num_factors(num_factors), .plan_done(plan_done), .plan_err(plan_err)
	);

	mrd_ctrl_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .sink_sop(sink_sop), .plan_done(plan_done),
		.plan_err(plan_err), .sink_last(sink_last), .calc_last(calc_last),
		.src_last(src_last), .state(state), .sink_start(sink_start),
		.calc_start(calc_start), .src_start(src_start), .frame_done(frame_done)
	);

	mrd_stage_counter u_cnt (
		.clk(clk), .rst_n(rst_n), .dftpts(dftpts), .sink_sop(sink_sop),
		.sink_start(sink_start), .calc_start(calc_start), .src_start(src_start),
		.nf(nf), .twdl_demontr(twdl_demontr), .num_factors(num_factors),
		.sample_idx(sample_idx), .elem(elem), .offset(offset), .block_base(block_base),
		.stage(stage), .count_valid(count_valid), .sink_last(sink_last),
		.calc_last(calc_last), .src_last(src_last)
	);

	mrd_addr_gen u_addr (
		.clk(clk), .rst_n(rst_n), .state(state), .count_valid(count_valid),
		.sample_idx(sample_idx), .elem(elem), .offset(offset), .block_base(block_base),
		.stage(stage), .twdl_demontr(twdl_demontr), .nf(nf), .mem_wr(mem_wr),
		.mem_rd(mem_rd), .src_valid(src_valid), .mem_addr(mem_addr),
		.stage_idx(stage_idx), .elem_idx(elem_idx)
	);

endmodule

/* dv/mrd_ctrl_checker.sv */
//--------------------------------------------------------------------
// mrd control output checks
// strobe exclusivity, reset behavior and address range
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_ctrl_checker (
	input logic          clk,
	input logic          rst_n,
	input logic          sink_start,
	input mrd_pkg::pts_t dftpts,
	input logic          mem_wr,
	input logic          mem_rd,
	input logic          src_valid,
	input mrd_pkg::pts_t mem_addr,
	input logic          frame_done
);

	mrd_pkg::pts_t n_lat;

	// frame length of the accepted sop
	always_ff @(posedge clk) begin
		if (sink_start)
			n_lat <= dftpts;
	end

	// one RAM port, one strobe
	strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({mem_wr, mem_rd, src_valid}))
		else $error("more than one memory strobe high");

	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !(mem_wr || mem_rd || src_valid || frame_done))
		else $error("strobe high in the cycle after reset");

	done_with_src: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |-> src_valid)
		else $error("frame_done without src_valid");

	addr_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_wr || mem_rd || src_valid) |-> (mem_addr < n_lat))
		else $error("mem_addr beyond the frame length");

endmodule

bind mrd_ctrl_top mrd_ctrl_checker u_checker (
	.clk(clk), .rst_n(rst_n), .sink_start(sink_start), .dftpts(dftpts),
	.mem_wr(mem_wr), .mem_rd(mem_rd), .src_valid(src_valid),
	.mem_addr(mem_addr), .frame_done(frame_done)
);

/* dv/mrd_tb.sv */
//--------------------------------------------------------------------
// mrd control testbench
// random frame sizes against a factor and address model
//--------------------------------------------------------------------
`timescale 1ns/100ps

module mrd_tb;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 2;
	localparam int NUM_FRAMES = 12;
	localparam int NUM_VALID  = 20;

	logic clk, rst_n, sink_sop;
	mrd_pkg::pts_t   dftpts, mem_addr;
	logic            mem_wr, mem_rd, src_valid, plan_err, frame_done;
	mrd_pkg::stage_t stage_idx;
	mrd_pkg::fac_t   elem_idx;
	mrd_pkg::nfac_t  num_factors;

	// products of 2, 3, 4 and 5, up to six factors
	int valid_sizes [NUM_VALID] = '{2, 3, 4, 5, 6, 8, 9, 12, 15, 16, 20, 24, 30,
		36, 45, 60, 120, 360, 1024, 3600};
	int sizes [NUM_FRAMES];
	int gaps [NUM_FRAMES];
	logic [31:0] rng = 32'd33;
	int errors = 0, tests = 0, failed = 0, cycles = 0, limit = 0;

	// model results for the frame in flight
	int exp_fac [mrd_pkg::MAX_STAGES];
	int exp_span [mrd_pkg::MAX_STAGES];
	int exp_nfac;
	logic exp_err, rd_seen, done_seen;
	// a strobe is owed in the next cycle
	logic strobe_due = 1'b0;
	// compute entry packs addr, stage << 16, elem << 24
	int wr_q[$], rd_q[$], src_q[$];

	mrd_ctrl_top UUT (
		.clk(clk), .rst_n(rst_n), .sink_sop(sink_sop), .dftpts(dftpts),
		.mem_wr(mem_wr), .mem_rd(mem_rd), .src_valid(src_valid), .mem_addr(mem_addr),
		.stage_idx(stage_idx), .elem_idx(elem_idx), .num_factors(num_factors),
		.plan_err(plan_err), .frame_done(frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// compute may run six passes over the frame
	function automatic int frame_budget(input int n, input int gap);
		return (mrd_pkg::MAX_STAGES + 2) * n + gap + mrd_pkg::PLAN_CYCLES + 20;
	endfunction

	task automatic flag_error(input string what);
		$display("%0t: %s", $time, what);
		errors++;
	endtask

	task automatic check_eq(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	//------------------------------------------------------------------
	// reference model
	//------------------------------------------------------------------

	// six steps, first of 4, 2, 5, 3 that divides, else 1
	task automatic factor_model(input int n);
		int r;
		int f;
		r = n;
		exp_nfac = 0;
		for (int i = 0; i < mrd_pkg::MAX_STAGES; i++) begin
			if (r % 4 == 0) f = 4;
			else if (r % 2 == 0) f = 2;
			else if (r % 5 == 0) f = 5;
			else if (r % 3 == 0) f = 3;
			else f = 1;
			if (f != 1) begin
				exp_fac[exp_nfac]  = f;
				exp_span[exp_nfac] = r;
				exp_nfac++;
			end
			r = r / f;
		end
		exp_err = (r != 1);
	endtask

	task automatic build_expect(input int n);
		int lp;
		wr_q.delete();
		rd_q.delete();
		src_q.delete();
		factor_model(n);
		for (int k = 0; k < n; k++) begin
			wr_q.push_back(k);
			src_q.push_back(k);
		end
		// m fastest, then j, then block base, then stage
		for (int s = 0; s < exp_nfac && !exp_err; s++) begin
			lp = exp_span[s] / exp_fac[s];
			for (int b = 0; b < n; b += exp_span[s])
				for (int j = 0; j < lp; j++)
					for (int m = 0; m < exp_fac[s]; m++)
						rd_q.push_back(b + j + m * lp + (s << 16) + (m << 24));
		end
		rd_seen   = 1'b0;
		done_seen = 1'b0;
	endtask

	//------------------------------------------------------------------
	// output monitor, mid cycle
	//------------------------------------------------------------------

	always @(negedge clk) begin
		int e;
		// sink starts the cycle after sop, phases run without gaps
		assert (!rst_n || !strobe_due || mem_wr || mem_rd || src_valid)
			else flag_error("no strobe in a cycle where the phase should still run");
		if (mem_wr) begin
			assert (wr_q.size() != 0) else flag_error("mem_wr with no write expected");
			if (wr_q.size() != 0) check_eq("mem_addr", int'(mem_addr), wr_q.pop_front());
		end
		if (mem_rd) begin
			assert (wr_q.size() == 0) else flag_error("mem_rd before the sink phase ended");
			assert (rd_q.size() != 0) else flag_error("mem_rd with no read expected");
			if (!rd_seen) check_eq("num_factors", int'(num_factors), exp_nfac);
			rd_seen = 1'b1;
			if (rd_q.size() != 0) begin
				e = rd_q.pop_front();
				check_eq("mem_addr", int'(mem_addr), e % 65536);
				check_eq("stage_idx", int'(stage_idx), (e >> 16) % 256);
				check_eq("elem_idx", int'(elem_idx), e >> 24);
			end
		end
		if (src_valid) begin
			assert (rd_q.size() == 0) else flag_error("src_valid before compute ended");
			assert (src_q.size() != 0) else flag_error("src_valid with no output expected");
			if (src_q.size() != 0) check_eq("mem_addr", int'(mem_addr), src_q.pop_front());
		end
		if (frame_done) begin
			assert (src_valid && src_q.size() == 0)
				else flag_error("frame_done not on the last src_valid");
			check_eq("plan_err", int'(plan_err), int'(exp_err));
			done_seen = 1'b1;
		end
		// compute hands over to source on the next cycle
		strobe_due = rst_n && (((sink_sop || mem_wr) && wr_q.size() != 0) || mem_rd ||
			(src_valid && src_q.size() != 0));
	end

	// run limit from the frame list
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, a frame never finished", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//------------------------------------------------------------------
	// frame tasks
	//------------------------------------------------------------------

	task automatic send_sop(input int n);
		@(posedge clk);
		#DRIVE_DLY;
		sink_sop = 1'b1;
		dftpts   = mrd_pkg::pts_t'(n);
		@(posedge clk);
		#DRIVE_DLY;
		sink_sop = 1'b0;
		dftpts   = '0;
	endtask

	task automatic finish_test(input string name, input int n, input int errs_before);
		tests++;
		if (errors != errs_before) failed++;
		$display("test %0d %s size %0d factors %0d plan_err %0d: %s", tests, name, n,
			exp_nfac, exp_err, (errors == errs_before) ? "ok" : "errors");
	endtask

	task automatic run_frame(input int n, input int gap);
		int errs_before;
		errs_before = errors;
		build_expect(n);
		repeat (gap) @(posedge clk);
		send_sop(n);
		while (!done_seen) @(posedge clk);
		assert (wr_q.size() == 0 && rd_q.size() == 0 && src_q.size() == 0)
			else flag_error("frame ended with strobes still missing");
		finish_test("frame", n, errs_before);
	endtask

	task automatic reset_mid_frame(input int n);
		int errs_before;
		errs_before = errors;
		build_expect(n);
		send_sop(n);
		// past the sink, into compute
		repeat (n + 12) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (!mem_wr && !mem_rd && !src_valid && !frame_done && !plan_err)
			else flag_error("outputs active while reset is held");
		wr_q.delete();
		rd_q.delete();
		src_q.delete();
		@(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		finish_test("reset", n, errs_before);
	endtask

	initial begin
		rst_n    = 1'b0;
		sink_sop = 1'b0;
		dftpts   = '0;
		limit    = 4 + frame_budget(60, 40) + frame_budget(120, 0);
		// every fourth frame has a factor of 7
		for (int t = 0; t < NUM_FRAMES; t++) begin
			if (t % 4 == 3)
				sizes[t] = 7 * (int'(xorshift32() % 32'd40) + 1);
			else
				sizes[t] = valid_sizes[int'(xorshift32() % NUM_VALID)];
			gaps[t] = int'(xorshift32() % 32'd6);
			limit += frame_budget(sizes[t], gaps[t]);
		end
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		for (int t = 0; t < NUM_FRAMES; t++)
			run_frame(sizes[t], gaps[t]);
		reset_mid_frame(60);
		run_frame(120, 0);
		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* build.f */
src/mrd_pkg.sv
src/mrd_factor_plan.sv
src/mrd_ctrl_fsm.sv
src/mrd_stage_counter.sv
src/mrd_addr_gen.sv
src/mrd_ctrl_top.sv
dv/mrd_ctrl_checker.sv
dv/mrd_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the mrd control testbench with Verilator
cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module mrd_tb -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$OBJ_DIR/Vmrd_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the testbench output
if grep -q "Simulation finished: PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
